// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // cache geometry, fixed for this core
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int L1I_SETS    = 4;
  localparam int SET_BITS    = 2;
  localparam int LINE_WORDS  = 2;
  localparam int OFFSET_BITS = 1;
  localparam int TAG_BITS    = ADDR_W - SET_BITS - OFFSET_BITS - 2;

  // fence.i, funct3 = 001 on the MISC-MEM opcode
  localparam logic [DATA_W-1:0] FENCE_I_WORD = 32'h0000_100f;

  // cache controller states
  localparam logic [1:0] CACHE_LOOKUP  = 2'd0;
  localparam logic [1:0] CACHE_FILL    = 2'd1;
  localparam logic [1:0] CACHE_DELIVER = 2'd2;

  // apb master states
  localparam logic [1:0] APB_IDLE   = 2'd0;
  localparam logic [1:0] APB_SETUP  = 2'd1;
  localparam logic [1:0] APB_ACCESS = 2'd2;

  // a fetch address, either as the bus word or split for the cache
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_BITS-1:0]    tag;
      logic [SET_BITS-1:0]    index;
      logic [OFFSET_BITS-1:0] offset;
      logic [1:0]             byte_sel;
    } fields;
  } fetch_addr_u;

endpackage

// ==== verilog/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             start_i,
  input  logic [fetch_pkg::ADDR_W-1:0]     start_pc_i,
  input  logic                             redirect_i,
  input  logic [fetch_pkg::ADDR_W-1:0]     redirect_pc_i,

  output logic                             req_valid_o,
  input  logic                             req_ready_i,
  output fetch_pkg::fetch_addr_u           req_addr_o
);

  logic                         active;
  logic [fetch_pkg::ADDR_W-1:0] pc;

  // once started the sequencer keeps requesting until reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active <= 1'b0;
    end
    else if (redirect_i || start_i)
    begin
      active <= 1'b1;
    end
  end

  // redirect takes priority over start
  always_ff @(posedge clk)
  begin
    if (redirect_i)
    begin
      pc <= {redirect_pc_i[fetch_pkg::ADDR_W-1:2], 2'b00};
    end
    else if (start_i)
    begin
      pc <= {start_pc_i[fetch_pkg::ADDR_W-1:2], 2'b00};
    end
    else if (active && req_ready_i)
    begin
      // next sequential word after each accepted request
      pc <= pc + fetch_pkg::ADDR_W'(4);
    end
  end

  assign req_valid_o    = active;
  assign req_addr_o.raw = pc;

endmodule

// ==== verilog/l1i_cache.sv ====
`timescale 1ns/1ps

module l1i_cache (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  fetch_pkg::fetch_addr_u              req_addr_i,

  output logic                                hit_valid_o,
  input  logic                                hit_ready_i,
  output logic [fetch_pkg::DATA_W-1:0]        hit_inst_o,
  output logic [fetch_pkg::ADDR_W-1:0]        hit_pc_o,

  input  logic                                redirect_i,
  input  logic                                fence_flush_i,

  output logic                                fill_req_o,
  output fetch_pkg::fetch_addr_u              fill_addr_o,
  input  logic                                fill_word_valid_i,
  input  logic [fetch_pkg::OFFSET_BITS-1:0]   fill_word_idx_i,
  input  logic [fetch_pkg::DATA_W-1:0]        fill_word_i,
  input  logic                                fill_done_i
);

  logic [fetch_pkg::DATA_W-1:0]   data_mem [0:fetch_pkg::L1I_SETS-1][0:fetch_pkg::LINE_WORDS-1];
  logic [fetch_pkg::TAG_BITS-1:0] tag_mem  [0:fetch_pkg::L1I_SETS-1];
  logic [fetch_pkg::L1I_SETS-1:0] valid_bits;

  logic [1:0]                     state;
  logic                           pend_valid;
  fetch_pkg::fetch_addr_u         pend_addr;

  logic [fetch_pkg::SET_BITS-1:0] idx;
  logic                           hit;
  logic                           deliver;
  logic                           accept;

  assign idx = pend_addr.fields.index;
  assign hit = valid_bits[idx] && (tag_mem[idx] == pend_addr.fields.tag);

  // after a fill the line is delivered straight from the data array
  assign hit_valid_o = pend_valid &&
                       (((state == fetch_pkg::CACHE_LOOKUP) && hit) ||
                        (state == fetch_pkg::CACHE_DELIVER));
  assign hit_inst_o  = data_mem[idx][pend_addr.fields.offset];
  assign hit_pc_o    = pend_addr.raw;

  assign deliver = hit_valid_o && hit_ready_i;

  // lookup slot is free when empty or handing its result over this cycle
  assign req_ready_o = !redirect_i &&
                       (((state == fetch_pkg::CACHE_LOOKUP) && (!pend_valid || deliver)) ||
                        ((state == fetch_pkg::CACHE_DELIVER) && deliver));
  assign accept      = req_valid_i && req_ready_o;

  // line base of the pending request
  always_comb
  begin
    fill_addr_o                 = pend_addr;
    fill_addr_o.fields.offset   = '0;
    fill_addr_o.fields.byte_sel = '0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= fetch_pkg::CACHE_LOOKUP;
      pend_valid <= 1'b0;
      fill_req_o <= 1'b0;
      valid_bits <= '0;
    end
    else
    begin
      fill_req_o <= 1'b0;

      case (state)
        fetch_pkg::CACHE_LOOKUP:
        begin
          if (pend_valid && !hit && !redirect_i)
          begin
            state      <= fetch_pkg::CACHE_FILL;
            fill_req_o <= 1'b1;
          end
        end
        fetch_pkg::CACHE_FILL:
        begin
          // a redirect during the fill still lets the line land
          if (fill_done_i)
          begin
            state <= (pend_valid && !redirect_i) ? fetch_pkg::CACHE_DELIVER
                                                 : fetch_pkg::CACHE_LOOKUP;
          end
        end
        fetch_pkg::CACHE_DELIVER:
        begin
          if (deliver || redirect_i)
          begin
            state <= fetch_pkg::CACHE_LOOKUP;
          end
        end
        default:
        begin
          state <= fetch_pkg::CACHE_LOOKUP;
        end
      endcase

      if (redirect_i)
      begin
        pend_valid <= 1'b0;
      end
      else if (accept)
      begin
        pend_valid <= 1'b1;
      end
      else if (deliver)
      begin
        pend_valid <= 1'b0;
      end

      if (fill_done_i)
      begin
        valid_bits[idx] <= 1'b1;
      end

      // invalidate-all wins over a line completing in the same cycle
      if (fence_flush_i)
      begin
        valid_bits <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pend_addr <= req_addr_i;
    end
  end

  // data and tag arrays
  always_ff @(posedge clk)
  begin
    if (fill_word_valid_i)
    begin
      data_mem[idx][fill_word_idx_i] <= fill_word_i;
    end
    if (fill_done_i)
    begin
      tag_mem[idx] <= pend_addr.fields.tag;
    end
  end

endmodule

// ==== verilog/apb_line_fetch.sv ====
`timescale 1ns/1ps

module apb_line_fetch (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                fill_req_i,
  input  fetch_pkg::fetch_addr_u              fill_addr_i,

  output logic                                fill_word_valid_o,
  output logic [fetch_pkg::OFFSET_BITS-1:0]   fill_word_idx_o,
  output logic [fetch_pkg::DATA_W-1:0]        fill_word_o,
  output logic                                fill_done_o,

  output logic [fetch_pkg::ADDR_W-1:0]        apb_paddr_o,
  output logic                                apb_psel_o,
  output logic                                apb_penable_o,
  output logic                                apb_pwrite_o,
  input  logic [fetch_pkg::DATA_W-1:0]        apb_prdata_i,
  input  logic                                apb_pready_i
);

  logic [1:0]                           state;
  logic [fetch_pkg::OFFSET_BITS-1:0]    word_idx;
  fetch_pkg::fetch_addr_u               line_base;
  fetch_pkg::fetch_addr_u               bus_addr;
  logic                                 last_word;

  assign last_word = (word_idx == fetch_pkg::OFFSET_BITS'(fetch_pkg::LINE_WORDS - 1));

  // one setup then access cycles until pready, once per word
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= fetch_pkg::APB_IDLE;
      word_idx <= '0;
    end
    else
    begin
      case (state)
        fetch_pkg::APB_IDLE:
        begin
          if (fill_req_i)
          begin
            state    <= fetch_pkg::APB_SETUP;
            word_idx <= '0;
          end
        end
        fetch_pkg::APB_SETUP:
        begin
          state <= fetch_pkg::APB_ACCESS;
        end
        fetch_pkg::APB_ACCESS:
        begin
          if (apb_pready_i)
          begin
            state    <= last_word ? fetch_pkg::APB_IDLE : fetch_pkg::APB_SETUP;
            word_idx <= word_idx + 1'b1;
          end
        end
        default:
        begin
          state <= fetch_pkg::APB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == fetch_pkg::APB_IDLE) && fill_req_i)
    begin
      line_base <= fill_addr_i;
    end
  end

  // word select goes into the offset field of the line base
  always_comb
  begin
    bus_addr               = line_base;
    bus_addr.fields.offset = word_idx;
  end

  assign apb_paddr_o   = bus_addr.raw;
  assign apb_psel_o    = (state != fetch_pkg::APB_IDLE);
  assign apb_penable_o = (state == fetch_pkg::APB_ACCESS);
  // read-only master
  assign apb_pwrite_o  = 1'b0;

  assign fill_word_valid_o = (state == fetch_pkg::APB_ACCESS) && apb_pready_i;
  assign fill_word_idx_o   = word_idx;
  assign fill_word_o       = apb_prdata_i;
  assign fill_done_o       = fill_word_valid_o && last_word;

endmodule

// ==== verilog/fetch_out_stage.sv ====
`timescale 1ns/1ps

module fetch_out_stage (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            hit_valid_i,
  output logic                            hit_ready_o,
  input  logic [fetch_pkg::DATA_W-1:0]    hit_inst_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    hit_pc_i,

  input  logic                            redirect_i,

  output logic                            inst_valid_o,
  output logic [fetch_pkg::DATA_W-1:0]    inst_o,
  output logic [fetch_pkg::ADDR_W-1:0]    inst_pc_o,
  input  logic                            inst_ready_i,

  output logic                            fence_flush_o
);

  logic                         full;
  logic [fetch_pkg::DATA_W-1:0] inst_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic                         drain;
  logic                         load;

  assign drain       = full && inst_ready_i;
  // room when empty or emptying this cycle
  assign hit_ready_o = !full || inst_ready_i;
  assign load        = hit_valid_i && hit_ready_o;

  always_ff @(posedge clk)
  begin
    if (rst || redirect_i)
    begin
      full <= 1'b0;
    end
    else if (load)
    begin
      full <= 1'b1;
    end
    else if (drain)
    begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      inst_q <= hit_inst_i;
      pc_q   <= hit_pc_i;
    end
  end

  assign inst_valid_o = full;
  assign inst_o       = inst_q;
  assign inst_pc_o    = pc_q;

  // flush the cache as the fence.i leaves
  assign fence_flush_o = drain && (inst_q == fetch_pkg::FENCE_I_WORD);

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            start_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    start_pc_i,
  input  logic                            redirect_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    redirect_pc_i,

  output logic [fetch_pkg::ADDR_W-1:0]    apb_paddr_o,
  output logic                            apb_psel_o,
  output logic                            apb_penable_o,
  output logic                            apb_pwrite_o,
  input  logic [fetch_pkg::DATA_W-1:0]    apb_prdata_i,
  input  logic                            apb_pready_i,

  output logic                            inst_valid_o,
  output logic [fetch_pkg::DATA_W-1:0]    inst_o,
  output logic [fetch_pkg::ADDR_W-1:0]    inst_pc_o,
  input  logic                            inst_ready_i
);

  // pc sequencer to cache
  logic                                req_valid;
  logic                                req_ready;
  fetch_pkg::fetch_addr_u              req_addr;

  // cache to output stage
  logic                                hit_valid;
  logic                                hit_ready;
  logic [fetch_pkg::DATA_W-1:0]        hit_inst;
  logic [fetch_pkg::ADDR_W-1:0]        hit_pc;
  logic                                fence_flush;

  // cache to line fetch
  logic                                fill_req;
  fetch_pkg::fetch_addr_u              fill_addr;
  logic                                fill_word_valid;
  logic [fetch_pkg::OFFSET_BITS-1:0]   fill_word_idx;
  logic [fetch_pkg::DATA_W-1:0]        fill_word;
  logic                                fill_done;

  pc_sequencer u_pc_sequencer (
    .clk (clk), .rst (rst),
    .start_i (start_i), .start_pc_i (start_pc_i),
    .redirect_i (redirect_i), .redirect_pc_i (redirect_pc_i),
    .req_valid_o (req_valid), .req_ready_i (req_ready), .req_addr_o (req_addr)
  );

  l1i_cache u_l1i_cache (
    .clk (clk), .rst (rst),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
    .hit_valid_o (hit_valid), .hit_ready_i (hit_ready),
    .hit_inst_o (hit_inst), .hit_pc_o (hit_pc),
    .redirect_i (redirect_i), .fence_flush_i (fence_flush),
    .fill_req_o (fill_req), .fill_addr_o (fill_addr),
    .fill_word_valid_i (fill_word_valid), .fill_word_idx_i (fill_word_idx),
    .fill_word_i (fill_word), .fill_done_i (fill_done)
  );

  apb_line_fetch u_apb_line_fetch (
    .clk (clk), .rst (rst),
    .fill_req_i (fill_req), .fill_addr_i (fill_addr),
    .fill_word_valid_o (fill_word_valid), .fill_word_idx_o (fill_word_idx),
    .fill_word_o (fill_word), .fill_done_o (fill_done),
    .apb_paddr_o (apb_paddr_o), .apb_psel_o (apb_psel_o),
    .apb_penable_o (apb_penable_o), .apb_pwrite_o (apb_pwrite_o),
    .apb_prdata_i (apb_prdata_i), .apb_pready_i (apb_pready_i)
  );

  fetch_out_stage u_fetch_out_stage (
    .clk (clk), .rst (rst),
    .hit_valid_i (hit_valid), .hit_ready_o (hit_ready),
    .hit_inst_i (hit_inst), .hit_pc_i (hit_pc),
    .redirect_i (redirect_i),
    .inst_valid_o (inst_valid_o), .inst_o (inst_o),
    .inst_pc_o (inst_pc_o), .inst_ready_i (inst_ready_i),
    .fence_flush_o (fence_flush)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held over the first two rising edges
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #10 rst <= 1'b0;
  end

endmodule

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] mem_i [0:63],
  input  logic        start_i,
  input  logic [31:0] start_pc_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  input  logic [31:0] apb_paddr_i,
  input  logic        apb_psel_i,
  input  logic        apb_penable_i,
  input  logic        apb_pwrite_i,
  input  logic        apb_pready_i,
  input  logic        inst_valid_i,
  input  logic [31:0] inst_i,
  input  logic [31:0] inst_pc_i,
  input  logic        inst_ready_i,
  input  logic [2:0]  test_id_i,
  input  logic        test_end_i,
  input  logic        watch_arm_i,
  input  logic [31:0] watch_line_i,
  input  logic [1:0]  watch_expect_i,
  input  logic        all_done_i,
  output int          deliv_count_o,
  output int          err_count_o
);

  logic [31:0] exp_pc;
  logic        hold_pending;
  logic [31:0] hold_inst;
  logic [31:0] hold_pc;
  // model of the cache valid and tag state
  logic [3:0]  mvalid;
  logic [26:0] mtag [0:3];
  logic        second_pending;
  logic [31:0] fill_base;
  logic [31:0] setup_addr;
  logic        flush;
  logic        watch_active;
  int          watch_cnt0;
  int          watch_cnt1;
  int          reads;
  int          errs_at_start;

  // expected instruction is the memory word at the pc
  function automatic logic [31:0] ref_inst(input logic [31:0] pc);
    return mem_i[pc[7:2]];
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "sequential stream";
      3'd2:    return "redirect to cached line";
      3'd3:    return "fence.i refetch";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_count_o = err_count_o + 1;
  endtask

  initial
  begin
    deliv_count_o = 0;
    err_count_o   = 0;
    reads         = 0;
    errs_at_start = 0;
    watch_active  = 1'b0;
    watch_cnt0    = 0;
    watch_cnt1    = 0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      exp_pc         = '0;
      hold_pending   = 1'b0;
      mvalid         = '0;
      second_pending = 1'b0;
    end
    else
    begin
      flush = 1'b0;

      // downstream output must hold under back-pressure
      if (hold_pending &&
          (!inst_valid_i || inst_i != hold_inst || inst_pc_i != hold_pc))
      begin
        report_mismatch($sformatf("output changed while stalled, pc %h", hold_pc));
      end
      if (inst_valid_i && inst_ready_i)
      begin
        if (inst_pc_i != exp_pc)
        begin
          report_mismatch($sformatf("pc %h delivered, expected %h", inst_pc_i, exp_pc));
        end
        else if (inst_i != ref_inst(inst_pc_i))
        begin
          report_mismatch($sformatf("pc %h gave %h, expected %h",
                                    inst_pc_i, inst_i, ref_inst(inst_pc_i)));
        end
        deliv_count_o = deliv_count_o + 1;
        exp_pc        = inst_pc_i + 32'd4;
        flush         = (inst_i == fetch_pkg::FENCE_I_WORD);
      end
      hold_pending = inst_valid_i && !inst_ready_i && !redirect_i;
      hold_inst    = inst_i;
      hold_pc      = inst_pc_i;
      if (redirect_i)
      begin
        exp_pc = {redirect_pc_i[31:2], 2'b00};
      end
      else if (start_i)
      begin
        exp_pc = {start_pc_i[31:2], 2'b00};
      end

      if (watch_arm_i)
      begin
        watch_active = 1'b1;
        watch_cnt0   = 0;
        watch_cnt1   = 0;
      end

      // apb side
      if (apb_psel_i && apb_pwrite_i)
      begin
        report_mismatch($sformatf("apb write at %h from a read-only master", apb_paddr_i));
      end
      if (apb_psel_i && !apb_penable_i)
      begin
        setup_addr = apb_paddr_i;
        if (!apb_paddr_i[2] && mvalid[apb_paddr_i[4:3]] &&
            mtag[apb_paddr_i[4:3]] == apb_paddr_i[31:5])
        begin
          report_mismatch($sformatf("bus read for cached line %h", apb_paddr_i));
        end
        if (apb_paddr_i[2] != second_pending)
        begin
          report_mismatch($sformatf("line words out of order at %h", apb_paddr_i));
        end
      end
      if (apb_psel_i && apb_penable_i)
      begin
        if (apb_paddr_i != setup_addr)
        begin
          report_mismatch($sformatf("apb address moved from %h", setup_addr));
        end
        if (apb_pready_i)
        begin
          reads = reads + 1;
          if (watch_active && apb_paddr_i == watch_line_i)
          begin
            watch_cnt0 = watch_cnt0 + 1;
          end
          if (watch_active && apb_paddr_i == watch_line_i + 32'd4)
          begin
            watch_cnt1 = watch_cnt1 + 1;
          end
          if (!apb_paddr_i[2])
          begin
            second_pending = 1'b1;
            fill_base      = apb_paddr_i;
          end
          else
          begin
            if (apb_paddr_i != fill_base + 32'd4)
            begin
              report_mismatch($sformatf("second read at %h, base %h", apb_paddr_i, fill_base));
            end
            second_pending            = 1'b0;
            mvalid[apb_paddr_i[4:3]]  = 1'b1;
            mtag[apb_paddr_i[4:3]]    = apb_paddr_i[31:5];
          end
        end
      end

      // invalidate-all beats a fill landing on the same edge
      if (flush)
      begin
        mvalid = '0;
      end

      if (test_end_i)
      begin
        if (watch_active && (watch_cnt0 != int'(watch_expect_i) ||
                             watch_cnt1 != int'(watch_expect_i)))
        begin
          report_mismatch($sformatf("line %h read %0d and %0d times, expected %0d",
                                    watch_line_i, watch_cnt0, watch_cnt1, watch_expect_i));
        end
        watch_active = 1'b0;
        $display("test %0d %s: %s, %0d errors", test_id_i, test_name(test_id_i),
                 (err_count_o == errs_at_start) ? "ok" : "failed",
                 err_count_o - errs_at_start);
        errs_at_start = err_count_o;
      end
      if (all_done_i)
      begin
        $display("deliveries %0d, apb reads %0d, errors %0d",
                 deliv_count_o, reads, err_count_o);
      end
    end
  end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam int          DRIVE_DLY  = 10;
  localparam int          WAIT_LIMIT = 4000;
  localparam logic [31:0] FENCE_ADDR = 32'h38;

  logic        clk;
  logic        rst;
  logic        start;
  logic [31:0] start_pc;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] apb_paddr;
  logic        apb_psel;
  logic        apb_penable;
  logic        apb_pwrite;
  logic [31:0] apb_prdata;
  logic        apb_pready;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_ready;
  logic [2:0]  test_id;
  logic        test_end;
  logic        watch_arm;
  logic [31:0] watch_line;
  logic [1:0]  watch_expect;
  logic        all_done;
  int          deliv_count;
  int          err_count;
  logic [31:0] mem [0:63];
  logic [15:0] lfsr;
  int          wait_left;
  logic        timed_out;
  int          base;

  tb_clock_gen u_clock_gen (.clk (clk), .rst (rst));

  fetch_top UUT (
    .clk (clk), .rst (rst),
    .start_i (start), .start_pc_i (start_pc),
    .redirect_i (redirect), .redirect_pc_i (redirect_pc),
    .apb_paddr_o (apb_paddr), .apb_psel_o (apb_psel),
    .apb_penable_o (apb_penable), .apb_pwrite_o (apb_pwrite),
    .apb_prdata_i (apb_prdata), .apb_pready_i (apb_pready),
    .inst_valid_o (inst_valid), .inst_o (inst),
    .inst_pc_o (inst_pc), .inst_ready_i (inst_ready)
  );

  tb_checker u_checker (
    .clk (clk), .rst (rst), .mem_i (mem),
    .start_i (start), .start_pc_i (start_pc),
    .redirect_i (redirect), .redirect_pc_i (redirect_pc),
    .apb_paddr_i (apb_paddr), .apb_psel_i (apb_psel),
    .apb_penable_i (apb_penable), .apb_pwrite_i (apb_pwrite),
    .apb_pready_i (apb_pready),
    .inst_valid_i (inst_valid), .inst_i (inst),
    .inst_pc_i (inst_pc), .inst_ready_i (inst_ready),
    .test_id_i (test_id), .test_end_i (test_end),
    .watch_arm_i (watch_arm), .watch_line_i (watch_line),
    .watch_expect_i (watch_expect), .all_done_i (all_done),
    .deliv_count_o (deliv_count), .err_count_o (err_count)
  );

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_deliveries(input int target);
    int n;
    n = 0;
    while (deliv_count < target && n < WAIT_LIMIT)
    begin
      step_cycle();
      n++;
    end
    if (deliv_count < target)
    begin
      $display("timeout: only %0d of %0d instructions were delivered", deliv_count, target);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_redirect(input logic [31:0] pc, input logic arm,
                               input logic [1:0] expect_reads);
    redirect     = 1'b1;
    redirect_pc  = pc;
    watch_arm    = arm;
    watch_line   = {pc[31:3], 3'b000};
    watch_expect = expect_reads;
    step_cycle();
    redirect  = 1'b0;
    watch_arm = 1'b0;
  endtask

  task automatic close_test(input logic [2:0] id);
    test_id  = id;
    test_end = 1'b1;
    step_cycle();
    test_end = 1'b0;
  endtask

  // apb memory with random wait states and random downstream ready
  always @(posedge clk)
  begin
    logic [31:0] v;
    #DRIVE_DLY;
    if (rst)
    begin
      apb_pready = 1'b0;
      inst_ready = 1'b0;
    end
    else
    begin
      apb_pready = 1'b0;
      if (apb_psel && !apb_penable)
      begin
        take_bits(2, v);
        wait_left = int'(v);
      end
      else if (apb_psel && apb_penable)
      begin
        if (wait_left == 0)
        begin
          apb_pready = 1'b1;
          apb_prdata = mem[apb_paddr[7:2]];
        end
        else
        begin
          wait_left--;
        end
      end
      take_bits(2, v);
      inst_ready = (v[1:0] != 2'b00);
    end
  end

  initial
  begin
    logic [31:0] v;
    int          n;
    lfsr = 16'd50124;
    start = 1'b0;
    start_pc = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    apb_prdata = '0;
    apb_pready = 1'b0;
    inst_ready = 1'b0;
    test_id = '0;
    test_end = 1'b0;
    watch_arm = 1'b0;
    watch_line = '0;
    watch_expect = '0;
    all_done = 1'b0;
    wait_left = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      take_bits(32, v);
      // only one fence.i in the image
      if (v == fetch_pkg::FENCE_I_WORD)
      begin
        v = v ^ 32'h1;
      end
      mem[i] = v;
    end
    mem[FENCE_ADDR[7:2]] = fetch_pkg::FENCE_I_WORD;

    n = 0;
    step_cycle();
    while (rst && n < WAIT_LIMIT)
    begin
      step_cycle();
      n++;
    end
    if (rst)
    begin
      $display("timeout: reset never released");
      timed_out = 1'b1;
    end

    if (!timed_out)
    begin
      start = 1'b1;
      step_cycle();
      start = 1'b0;
      wait_deliveries(12);
    end
    if (!timed_out)
    begin
      close_test(3'd1);
      // line 0x20 is still cached, so no reads expected
      send_redirect(32'h23, 1'b1, 2'd0);
      base = deliv_count;
      wait_deliveries(base + 4);
    end
    if (!timed_out)
    begin
      close_test(3'd2);
      send_redirect(32'h30, 1'b0, 2'd0);
      base = deliv_count;
      wait_deliveries(base + 3);
    end
    if (!timed_out)
    begin
      // fence.i has left, so line 0x28 must be fetched again
      send_redirect(32'h2a, 1'b1, 2'd1);
      base = deliv_count;
      wait_deliveries(base + 4);
    end
    if (!timed_out)
    begin
      close_test(3'd3);
    end
    all_done = 1'b1;
    step_cycle();
    all_done = 1'b0;
    if (timed_out || err_count != 0)
    begin
      $display("TB FAILED");
    end
    else
    begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/fetch_pkg.sv
verilog/pc_sequencer.sv
verilog/l1i_cache.sv
verilog/apb_line_fetch.sv
verilog/fetch_out_stage.sv
verilog/fetch_top.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
